// File: logic/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] insn_t;

    typedef enum logic [3:0] {
        OPC_INVALID,
        OPC_LDUR,
        OPC_STUR,
        OPC_MOVZ,
        OPC_MOVK,
        OPC_ADD,
        OPC_SUB,
        OPC_ADDS,
        OPC_SUBS,
        OPC_ORR,
        OPC_EOR,
        OPC_ANDS,
        OPC_B,
        OPC_NOP,
        OPC_HLT
    } opcode_t;

    // match/mask pairs over insn[31:21]
    localparam logic [10:0] LDUR_MATCH = 11'b11111000010;
    localparam logic [10:0] LDUR_MASK  = 11'b11111111111;
    localparam logic [10:0] STUR_MATCH = 11'b11111000000;
    localparam logic [10:0] STUR_MASK  = 11'b11111111111;
    localparam logic [10:0] MOVZ_MATCH = 11'b11010010100;
    localparam logic [10:0] MOVZ_MASK  = 11'b11111111100; // hw in 22:21
    localparam logic [10:0] MOVK_MATCH = 11'b11110010100;
    localparam logic [10:0] MOVK_MASK  = 11'b11111111100;
    localparam logic [10:0] ADD_MATCH  = 11'b10010001000;
    localparam logic [10:0] ADD_MASK   = 11'b11111111110; // bit 21 is imm12 msb
    localparam logic [10:0] SUB_MATCH  = 11'b11010001000;
    localparam logic [10:0] SUB_MASK   = 11'b11111111110;
    localparam logic [10:0] ADDS_MATCH = 11'b10101011000;
    localparam logic [10:0] ADDS_MASK  = 11'b11111111111;
    localparam logic [10:0] SUBS_MATCH = 11'b11101011000;
    localparam logic [10:0] SUBS_MASK  = 11'b11111111111;
    localparam logic [10:0] ORR_MATCH  = 11'b10101010000;
    localparam logic [10:0] ORR_MASK   = 11'b11111111111;
    localparam logic [10:0] EOR_MATCH  = 11'b11001010000;
    localparam logic [10:0] EOR_MASK   = 11'b11111111111;
    localparam logic [10:0] ANDS_MATCH = 11'b11101010000;
    localparam logic [10:0] ANDS_MASK  = 11'b11111111111;
    localparam logic [10:0] B_MATCH    = 11'b00010100000;
    localparam logic [10:0] B_MASK     = 11'b11111100000; // imm26 below
    localparam logic [10:0] NOP_MATCH  = 11'b11010101000;
    localparam logic [10:0] NOP_MASK   = 11'b11111111111;
    localparam logic [10:0] HLT_MATCH  = 11'b11010100010;
    localparam logic [10:0] HLT_MASK   = 11'b11111111111;

    // field positions
    localparam int RD_LSB    = 0;  // also Rt
    localparam int RN_LSB    = 5;
    localparam int RM_LSB    = 16;
    localparam int IMM12_LSB = 10;
    localparam int IMM9_LSB  = 12;
    localparam int IMM16_LSB = 5;
    localparam int HW_LSB    = 21;

    localparam logic [4:0] REG_SP = 5'd31;

endpackage

// File: logic/uop_pkg.sv
package uop_pkg;

    localparam int DECODE_WIDTH = 2;
    localparam int QUEUE_WIDTH  = 2 * DECODE_WIDTH; // up to two uops per word
    localparam int PUSH_W       = $clog2(QUEUE_WIDTH + 1);
    localparam int UOP_DATA_W   = 40;

    typedef enum logic [3:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_ORR,
        UOP_EOR,
        UOP_AND,
        UOP_MOVZ,
        UOP_MOVK,
        UOP_LOAD,
        UOP_STORE,
        UOP_HLT
    } uop_code_t;

    typedef struct packed {
        logic [4:0] gpr;
        logic       is_sp;
    } reg_ref_t;

    typedef struct packed {
        logic [3:0]  pad;
        reg_ref_t    dst;
        reg_ref_t    src;
        logic [20:0] imm;
        logic [1:0]  hw;
        logic        set_nzcv;
    } uop_ri_t;

    typedef struct packed {
        logic [20:0] pad;
        reg_ref_t    dst;
        reg_ref_t    src1;
        reg_ref_t    src2;
        logic        set_nzcv;
    } uop_rr_t;

    // valb_sel picks the view
    typedef union packed {
        uop_ri_t ri;
        uop_rr_t rr;
    } uop_data_u;

    typedef struct packed {
        uop_code_t   uop_code;
        logic [63:0] pc;
        uop_data_u   data;
        logic        valb_sel;
        logic        mem_read;
        logic        mem_write;
        logic        w_enable;
        logic        tx_begin;
        logic        tx_end;
    } uop_t;

    typedef struct packed {
        uop_t [1:0] uop;
        logic [1:0] count; // 0..2
    } slot_uops_t;

    typedef struct packed {
        uop_t [QUEUE_WIDTH-1:0] uops;
        logic [PUSH_W-1:0]      pushes;
    } uop_group_t;

endpackage

// File: logic/insn_classify.sv
module insn_classify import isa_pkg::*; (
    input  insn_t   insn,
    output opcode_t opcode
);

    logic [10:0] key;

    assign key = insn[31:21];

    // first match wins
    always_comb begin
        opcode = OPC_INVALID;
        if ((key & LDUR_MASK) == LDUR_MATCH)
            opcode = OPC_LDUR;
        else if ((key & STUR_MASK) == STUR_MATCH)
            opcode = OPC_STUR;
        else if ((key & MOVZ_MASK) == MOVZ_MATCH)
            opcode = OPC_MOVZ;
        else if ((key & MOVK_MASK) == MOVK_MATCH)
            opcode = OPC_MOVK;
        else if ((key & ADD_MASK) == ADD_MATCH)
            opcode = OPC_ADD;
        else if ((key & SUB_MASK) == SUB_MATCH)
            opcode = OPC_SUB;
        else if ((key & ADDS_MASK) == ADDS_MATCH)
            opcode = OPC_ADDS;
        else if ((key & SUBS_MASK) == SUBS_MATCH)
            opcode = OPC_SUBS;
        else if ((key & ORR_MASK) == ORR_MATCH)
            opcode = OPC_ORR;
        else if ((key & EOR_MASK) == EOR_MATCH)
            opcode = OPC_EOR;
        else if ((key & ANDS_MASK) == ANDS_MATCH)
            opcode = OPC_ANDS;
        else if ((key & B_MASK) == B_MATCH)
            opcode = OPC_B;
        else if ((key & NOP_MASK) == NOP_MATCH)
            opcode = OPC_NOP; // whole hint space lands here
        else if ((key & HLT_MASK) == HLT_MATCH)
            opcode = OPC_HLT;
    end

endmodule

// File: logic/slot_decode.sv
module slot_decode import isa_pkg::*, uop_pkg::*; (
    input  insn_t       insn,
    input  opcode_t     opcode,
    input  logic [63:0] pc,
    output slot_uops_t  uops
);

    // address add of a cracked LDUR/STUR, result lands in Rt
    function automatic uop_t dec_mem_add(input insn_t w);
        uop_t       u;
        uop_ri_t    ri;
        logic [8:0] off;
        logic [8:0] mag;
        off = w[IMM9_LSB +: 9];
        mag = off[8] ? (~off + 9'd1) : off; // sub takes the magnitude
        u = '0;
        ri = '0;
        ri.dst.gpr = w[RD_LSB +: 5];
        ri.src.gpr = w[RN_LSB +: 5];
        ri.src.is_sp = (w[RN_LSB +: 5] == REG_SP);
        ri.imm = {12'b0, mag};
        u.data.ri = ri;
        u.uop_code = off[8] ? UOP_SUB : UOP_ADD;
        u.w_enable = 1'b1;
        u.tx_begin = 1'b1;
        return u;
    endfunction

    function automatic uop_t dec_mem(input insn_t w, input logic cracked, input logic load);
        uop_t    u;
        uop_ri_t ri;
        u = '0;
        ri = '0;
        ri.dst.gpr = w[RD_LSB +: 5];
        ri.src.gpr = cracked ? w[RD_LSB +: 5] : w[RN_LSB +: 5]; // base is Rt once added
        ri.src.is_sp = !cracked && (w[RN_LSB +: 5] == REG_SP);
        u.data.ri = ri;
        u.uop_code = load ? UOP_LOAD : UOP_STORE;
        u.mem_read = load;
        u.w_enable = load;
        u.mem_write = !load;
        u.tx_begin = !cracked;
        u.tx_end = 1'b1;
        return u;
    endfunction

    function automatic uop_t dec_move(input insn_t w, input logic keep);
        uop_t    u;
        uop_ri_t ri;
        u = '0;
        ri = '0;
        ri.dst.gpr = w[RD_LSB +: 5];
        ri.imm = {5'b0, w[IMM16_LSB +: 16]};
        ri.hw = keep ? w[HW_LSB +: 2] : 2'b0;
        u.data.ri = ri;
        u.uop_code = keep ? UOP_MOVK : UOP_MOVZ;
        u.w_enable = 1'b1;
        u.tx_begin = 1'b1;
        u.tx_end = 1'b1;
        return u;
    endfunction

    // add/sub immediate, register 31 reads as sp
    function automatic uop_t dec_ri(input insn_t w, input uop_code_t code);
        uop_t    u;
        uop_ri_t ri;
        u = '0;
        ri = '0;
        ri.dst.gpr = w[RD_LSB +: 5];
        ri.dst.is_sp = (w[RD_LSB +: 5] == REG_SP);
        ri.src.gpr = w[RN_LSB +: 5];
        ri.src.is_sp = (w[RN_LSB +: 5] == REG_SP);
        ri.imm = {9'b0, w[IMM12_LSB +: 12]};
        u.data.ri = ri;
        u.uop_code = code;
        u.w_enable = 1'b1;
        u.tx_begin = 1'b1;
        u.tx_end = 1'b1;
        return u;
    endfunction

    function automatic uop_t dec_rr(input insn_t w, input uop_code_t code, input logic flags);
        uop_t    u;
        uop_rr_t rr;
        u = '0;
        rr = '0;
        rr.dst.gpr = w[RD_LSB +: 5];
        rr.src1.gpr = w[RN_LSB +: 5];
        rr.src2.gpr = w[RM_LSB +: 5];
        rr.set_nzcv = flags;
        u.data.rr = rr;
        u.uop_code = code;
        u.valb_sel = 1'b1;
        u.w_enable = 1'b1;
        u.tx_begin = 1'b1;
        u.tx_end = 1'b1;
        return u;
    endfunction

    always_comb begin
        logic load;
        logic cracked;
        load = (opcode == OPC_LDUR);
        cracked = (insn[IMM9_LSB +: 9] != 9'd0);
        uops = '0;
        case (opcode)
            OPC_LDUR, OPC_STUR: begin
                if (cracked) begin
                    uops.uop[0] = dec_mem_add(insn);
                    uops.uop[1] = dec_mem(insn, 1'b1, load);
                    uops.count = 2'd2;
                end else begin
                    uops.uop[0] = dec_mem(insn, 1'b0, load);
                    uops.count = 2'd1;
                end
            end
            OPC_MOVZ, OPC_MOVK: begin
                uops.uop[0] = dec_move(insn, opcode == OPC_MOVK);
                uops.count = 2'd1;
            end
            OPC_ADD: begin
                uops.uop[0] = dec_ri(insn, UOP_ADD);
                uops.count = 2'd1;
            end
            OPC_SUB: begin
                uops.uop[0] = dec_ri(insn, UOP_SUB);
                uops.count = 2'd1;
            end
            OPC_ADDS: begin
                uops.uop[0] = dec_rr(insn, UOP_ADD, 1'b1);
                uops.count = 2'd1;
            end
            OPC_SUBS: begin
                uops.uop[0] = dec_rr(insn, UOP_SUB, 1'b1);
                uops.count = 2'd1;
            end
            OPC_ORR: begin
                uops.uop[0] = dec_rr(insn, UOP_ORR, 1'b0);
                uops.count = 2'd1;
            end
            OPC_EOR: begin
                uops.uop[0] = dec_rr(insn, UOP_EOR, 1'b0);
                uops.count = 2'd1;
            end
            OPC_ANDS: begin
                uops.uop[0] = dec_rr(insn, UOP_AND, 1'b1);
                uops.count = 2'd1;
            end
            OPC_HLT: begin
                uops.uop[0].uop_code = UOP_HLT;
                uops.uop[0].tx_begin = 1'b1;
                uops.uop[0].tx_end = 1'b1;
                uops.count = 2'd1;
            end
            default: uops.count = 2'd0; // B, NOP and unknown words vanish
        endcase
        for (int k = 0; k < 2; k++) begin
            if (k < uops.count)
                uops.uop[k].pc = pc;
        end
    end

endmodule

// File: logic/uop_compact.sv
module uop_compact import uop_pkg::*; #(
    parameter int SUPER_SCALAR_WIDTH = DECODE_WIDTH
) (
    input  slot_uops_t [SUPER_SCALAR_WIDTH-1:0] slots,
    output uop_group_t                          group
);

    // slot order is program order, so packing keeps it
    always_comb begin
        int unsigned idx;
        group = '0;
        idx = 0;
        for (int s = 0; s < SUPER_SCALAR_WIDTH; s++) begin
            for (int k = 0; k < 2; k++) begin
                if (k < slots[s].count && idx < QUEUE_WIDTH) begin
                    group.uops[idx] = slots[s].uop[k];
                    idx++;
                end
            end
        end
        group.pushes = PUSH_W'(idx);
    end

endmodule

// File: logic/decode_skid.sv
module decode_skid import uop_pkg::*; (
    input  logic       clk_in,
    input  logic       arst_n,
    input  logic       flush,
    input  logic       fetch_valid,
    output logic       decode_ready,
    input  uop_group_t group_in,
    input  logic       exe_ready,
    output logic       decode_valid,
    output uop_group_t queue_group
);

    uop_group_t out_q;
    uop_group_t spare_q;
    logic       out_valid;
    logic       spare_valid;
    logic       take;      // accepted and worth keeping
    logic       out_free;  // output stage empty or draining
    logic       load_out;

    assign decode_ready = !spare_valid;
    assign take         = fetch_valid && decode_ready && (group_in.pushes != '0);
    assign out_free     = !out_valid || exe_ready;
    assign load_out     = out_free && (spare_valid || take);

    assign decode_valid = out_valid;
    assign queue_group  = out_q;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            spare_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
            spare_valid <= 1'b0;
        end else if (out_free) begin
            out_valid <= spare_valid || take; // spare first, fetch is stalled then
            spare_valid <= 1'b0;
        end else if (take) begin
            spare_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (load_out)
            out_q <= spare_valid ? spare_q : group_in;
        if (take && !out_free)
            spare_q <= group_in;
    end

endmodule

// File: logic/decode_top.sv
module decode_top import isa_pkg::*, uop_pkg::*; #(
    parameter int SUPER_SCALAR_WIDTH = DECODE_WIDTH
) (
    input  logic                                 clk_in,
    input  logic                                 arst_n,
    input  logic                                 flush,
    input  logic                                 fetch_valid,
    input  insn_t [SUPER_SCALAR_WIDTH-1:0]       fetch_insn,
    input  logic  [SUPER_SCALAR_WIDTH-1:0][63:0] fetch_pc,
    output logic                                 decode_ready,
    input  logic                                 exe_ready,
    output logic                                 decode_valid,
    output uop_group_t                           queue_group
);

    opcode_t    [SUPER_SCALAR_WIDTH-1:0] slot_opcode;
    slot_uops_t [SUPER_SCALAR_WIDTH-1:0] slot_uops;
    uop_group_t                          packed_group;

    for (genvar s = 0; s < SUPER_SCALAR_WIDTH; s++) begin : g_slot
        insn_classify insn_classify_inst (
            .insn   (fetch_insn[s]),
            .opcode (slot_opcode[s])
        );

        slot_decode slot_decode_inst (
            .insn   (fetch_insn[s]),
            .opcode (slot_opcode[s]),
            .pc     (fetch_pc[s]),
            .uops   (slot_uops[s])
        );
    end

    uop_compact #(
        .SUPER_SCALAR_WIDTH (SUPER_SCALAR_WIDTH)
    ) uop_compact_inst (
        .slots (slot_uops),
        .group (packed_group)
    );

    decode_skid decode_skid_inst (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .flush        (flush),
        .fetch_valid  (fetch_valid),
        .decode_ready (decode_ready),
        .group_in     (packed_group),
        .exe_ready    (exe_ready),
        .decode_valid (decode_valid),
        .queue_group  (queue_group)
    );

endmodule

// File: tests/decode_properties.sv
module decode_properties import uop_pkg::*; (
    input logic       clk_in,
    input logic       arst_n,
    input logic       flush,
    input logic       exe_ready,
    input logic       decode_valid,
    input uop_group_t queue_group
);

    // stalled group stays put unless flushed
    property stall_holds;
        @(posedge clk_in) disable iff (!arst_n)
            decode_valid && !exe_ready && !flush |=> decode_valid && $stable(queue_group);
    endproperty

    property valid_has_work;
        @(posedge clk_in) disable iff (!arst_n)
            decode_valid |-> queue_group.pushes != '0;
    endproperty

    property flush_empties;
        @(posedge clk_in) disable iff (!arst_n)
            flush |=> !decode_valid;
    endproperty

    a_stall_holds: assert property (stall_holds)
        else $error("output group changed while stalled");
    a_valid_has_work: assert property (valid_has_work)
        else $error("empty group presented downstream");
    a_flush_empties: assert property (flush_empties)
        else $error("decode_valid still high after flush");

endmodule

bind decode_skid decode_properties decode_properties_inst (
    .clk_in       (clk_in),
    .arst_n       (arst_n),
    .flush        (flush),
    .exe_ready    (exe_ready),
    .decode_valid (decode_valid),
    .queue_group  (queue_group)
);

// File: tests/tb_decode.sv
module tb_decode import isa_pkg::*, uop_pkg::*; ();

    localparam int SSW        = DECODE_WIDTH;
    localparam int N_CYCLES   = 4000;
    localparam int WAIT_LIMIT = 200; // cycles a pending group may wait

    logic                  clk_in;
    logic                  arst_n;
    logic                  flush;
    logic                  fetch_valid;
    insn_t [SSW-1:0]       fetch_insn;
    logic  [SSW-1:0][63:0] fetch_pc;
    logic                  decode_ready;
    logic                  exe_ready;
    logic                  decode_valid;
    uop_group_t            queue_group;

    integer      seed;
    uop_group_t  expected[$];
    int          stall_cycles;
    logic        after_flush;
    logic        was_stalled;
    uop_group_t  held_group;
    logic [10:0] match_tab [14];
    logic [10:0] mask_tab [14];
    opcode_t     opc_tab [14];

    decode_top #(.SUPER_SCALAR_WIDTH(SSW)) decode_top_inst (.*);

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic opcode_t classify_word(input insn_t w);
        for (int i = 0; i < 14; i++) begin
            if ((w[31:21] & mask_tab[i]) == match_tab[i])
                return opc_tab[i];
        end
        return OPC_INVALID;
    endfunction

    // expected group for one bundle, straight from the decode rules
    function automatic uop_group_t decode_bundle(input insn_t [SSW-1:0] words,
                                                 input logic [SSW-1:0][63:0] pcs);
        uop_group_t g;
        uop_t       u;
        uop_ri_t    ri;
        uop_rr_t    rr;
        opcode_t    op;
        logic [8:0] off;
        logic [8:0] mag;
        logic [4:0] rd;
        logic [4:0] rn;
        logic       emit;
        g = '0;
        for (int s = 0; s < SSW; s++) begin
            op = classify_word(words[s]);
            rd = words[s][RD_LSB +: 5];
            rn = words[s][RN_LSB +: 5];
            off = words[s][IMM9_LSB +: 9];
            mag = off[8] ? (9'd0 - off) : off;
            u = '0;
            ri = '0;
            rr = '0;
            emit = 1'b1;
            u.pc = pcs[s];
            u.w_enable = 1'b1;
            u.tx_begin = 1'b1;
            u.tx_end = 1'b1;
            ri.dst.gpr = rd;
            ri.src.gpr = rn;
            case (op)
                OPC_LDUR, OPC_STUR: begin
                    ri.src.is_sp = (rn == REG_SP);
                    if (off != 9'd0) begin
                        ri.imm = {12'b0, mag}; // sub carries the magnitude
                        u.uop_code = off[8] ? UOP_SUB : UOP_ADD;
                        u.data.ri = ri;
                        u.tx_end = 1'b0;
                        g.uops[g.pushes] = u;
                        g.pushes++;
                        ri.imm = '0;
                        ri.src = '{gpr: rd, is_sp: 1'b0};
                        u.tx_begin = 1'b0;
                        u.tx_end = 1'b1;
                    end
                    u.uop_code = (op == OPC_LDUR) ? UOP_LOAD : UOP_STORE;
                    u.data.ri = ri;
                    u.w_enable = (op == OPC_LDUR);
                    u.mem_read = (op == OPC_LDUR);
                    u.mem_write = (op == OPC_STUR);
                end
                OPC_MOVZ, OPC_MOVK: begin
                    ri.src.gpr = 5'd0;
                    ri.imm = {5'b0, words[s][IMM16_LSB +: 16]};
                    ri.hw = (op == OPC_MOVK) ? words[s][HW_LSB +: 2] : 2'b0;
                    u.uop_code = (op == OPC_MOVK) ? UOP_MOVK : UOP_MOVZ;
                    u.data.ri = ri;
                end
                OPC_ADD, OPC_SUB: begin
                    ri.dst.is_sp = (rd == REG_SP);
                    ri.src.is_sp = (rn == REG_SP);
                    ri.imm = {9'b0, words[s][IMM12_LSB +: 12]};
                    u.uop_code = (op == OPC_ADD) ? UOP_ADD : UOP_SUB;
                    u.data.ri = ri;
                end
                OPC_ADDS, OPC_SUBS, OPC_ORR, OPC_EOR, OPC_ANDS: begin
                    rr.dst.gpr = rd;
                    rr.src1.gpr = rn;
                    rr.src2.gpr = words[s][RM_LSB +: 5];
                    rr.set_nzcv = (op == OPC_ADDS || op == OPC_SUBS || op == OPC_ANDS);
                    u.uop_code = (op == OPC_ADDS) ? UOP_ADD : (op == OPC_SUBS) ? UOP_SUB :
                                 (op == OPC_ORR) ? UOP_ORR : (op == OPC_EOR) ? UOP_EOR : UOP_AND;
                    u.data.rr = rr;
                    u.valb_sel = 1'b1;
                end
                OPC_HLT: begin
                    u.uop_code = UOP_HLT;
                    u.w_enable = 1'b0;
                end
                default: emit = 1'b0; // B, NOP and junk give nothing
            endcase
            if (emit) begin
                g.uops[g.pushes] = u;
                g.pushes++;
            end
        end
        return g;
    endfunction

    task automatic compare_uop(input uop_t got, input uop_t exp, input int idx);
        if (got !== exp)
            abort_run($sformatf("Fail at time %0t: uop %0d is %h, expected %h",
                                $time, idx, got, exp));
    endtask

    task automatic compare_group(input uop_group_t got, input uop_group_t exp);
        if (got.pushes !== exp.pushes) begin
            abort_run($sformatf("Fail at time %0t: push count %0d, expected %0d",
                                $time, got.pushes, exp.pushes));
        end else begin
            for (int i = 0; i < QUEUE_WIDTH; i++) begin
                if (i < exp.pushes)
                    compare_uop(got.uops[i], exp.uops[i], i);
            end
        end
    endtask

    task automatic check_idle(input string when_txt);
        if (decode_valid !== 1'b0 || decode_ready !== 1'b1)
            abort_run($sformatf("Fail at time %0t: outputs not idle %s", $time, when_txt));
    endtask

    task automatic make_word(output insn_t w);
        int pick;
        pick = $unsigned($random(seed)) % 17;
        w = $random(seed); // picks 14 and up stay junk
        if (pick < 14)
            w[31:21] = match_tab[pick] | (w[31:21] & ~mask_tab[pick]);
        if (pick < 2 && ($random(seed) & 3) == 0)
            w[IMM9_LSB +: 9] = 9'd0;
        if (($random(seed) & 7) == 0)
            w[RN_LSB +: 5] = REG_SP;
        if (($random(seed) & 7) == 0)
            w[RD_LSB +: 5] = REG_SP;
    endtask

    task automatic drive_inputs();
        insn_t w;
        flush = ($unsigned($random(seed)) % 64) == 0;
        fetch_valid = ($random(seed) & 3) != 0;
        exe_ready = !flush && (($random(seed) & 3) != 0);
        for (int s = 0; s < SSW; s++) begin
            make_word(w);
            fetch_insn[s] = w;
            fetch_pc[s] = {$random(seed), $random(seed)};
        end
    endtask

    // scoreboard, transfers pop before accepts push
    // groups in flight equal the pending queue, out entry first and then the spare
    always @(posedge clk_in) begin
        uop_group_t exp_g;
        if (!arst_n) begin
            after_flush = 1'b0;
            was_stalled = 1'b0;
            stall_cycles = 0;
        end else if (after_flush && decode_valid) begin
            abort_run($sformatf("Fail at time %0t: decode_valid high after flush", $time));
        end else if (was_stalled && (!decode_valid || queue_group !== held_group)) begin
            abort_run($sformatf("Fail at time %0t: output changed while stalled", $time));
        end else if (decode_valid !== (expected.size() != 0)) begin
            abort_run($sformatf("Fail at time %0t: decode_valid %b, %0d in flight",
                                $time, decode_valid, expected.size()));
        end else if (decode_ready !== (expected.size() < 2)) begin
            abort_run($sformatf("Fail at time %0t: decode_ready %b, %0d in flight",
                                $time, decode_ready, expected.size()));
        end else if (stall_cycles > WAIT_LIMIT) begin
            abort_run($sformatf("timeout at %0t: a pending group never transferred", $time));
        end else begin
            if (flush) begin
                expected.delete();
            end else begin
                if (decode_valid && exe_ready) begin
                    if (expected.size() == 0) begin
                        abort_run($sformatf("group transferred at %0t with nothing pending",
                                            $time));
                    end else begin
                        exp_g = expected.pop_front();
                        compare_group(queue_group, exp_g);
                    end
                end
                if (fetch_valid && decode_ready) begin
                    exp_g = decode_bundle(fetch_insn, fetch_pc);
                    if (exp_g.pushes != '0)
                        expected.push_back(exp_g);
                end
            end
            if (expected.size() != 0 && !(decode_valid && exe_ready))
                stall_cycles++;
            else
                stall_cycles = 0;
            after_flush = flush;
            was_stalled = decode_valid && !exe_ready && !flush;
            held_group = queue_group;
        end
    end

    initial begin
        int drain_wait;
        seed = 32'hdc5b5246;
        match_tab = '{LDUR_MATCH, STUR_MATCH, MOVZ_MATCH, MOVK_MATCH, ADD_MATCH, SUB_MATCH,
                      ADDS_MATCH, SUBS_MATCH, ORR_MATCH, EOR_MATCH, ANDS_MATCH, B_MATCH,
                      NOP_MATCH, HLT_MATCH};
        mask_tab = '{LDUR_MASK, STUR_MASK, MOVZ_MASK, MOVK_MASK, ADD_MASK, SUB_MASK,
                     ADDS_MASK, SUBS_MASK, ORR_MASK, EOR_MASK, ANDS_MASK, B_MASK,
                     NOP_MASK, HLT_MASK};
        opc_tab = '{OPC_LDUR, OPC_STUR, OPC_MOVZ, OPC_MOVK, OPC_ADD, OPC_SUB, OPC_ADDS,
                    OPC_SUBS, OPC_ORR, OPC_EOR, OPC_ANDS, OPC_B, OPC_NOP, OPC_HLT};
        arst_n = 1'b0;
        flush = 1'b0;
        fetch_valid = 1'b0;
        fetch_insn = '0;
        fetch_pc = '0;
        exe_ready = 1'b0;
        repeat (8) @(posedge clk_in);
        check_idle("during reset");
        @(negedge clk_in);
        arst_n = 1'b1;
        @(negedge clk_in);
        check_idle("after reset release");
        for (int c = 0; c < N_CYCLES; c++) begin
            drive_inputs();
            @(negedge clk_in);
        end
        fetch_valid = 1'b0;
        flush = 1'b0;
        exe_ready = 1'b1;
        drain_wait = 0;
        while ((expected.size() != 0 || decode_valid) && drain_wait < WAIT_LIMIT) begin
            @(negedge clk_in);
            drain_wait++;
        end
        if (expected.size() == 0 && !decode_valid) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run($sformatf("timeout: %0d groups still pending after drain",
                                expected.size()));
        end
    end

endmodule

// File: compile.f
logic/isa_pkg.sv
logic/uop_pkg.sv
logic/insn_classify.sv
logic/slot_decode.sv
logic/uop_compact.sv
logic/decode_skid.sv
logic/decode_top.sv
tests/decode_properties.sv
tests/tb_decode.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - logic/isa_pkg.sv
  - logic/uop_pkg.sv
  - logic/insn_classify.sv
  - logic/slot_decode.sv
  - logic/uop_compact.sv
  - logic/decode_skid.sv
  - logic/decode_top.sv
  - target: test
    files:
      - tests/decode_properties.sv
      - tests/tb_decode.sv
